//--- list.f
rtl/irq_pkg.sv
rtl/core_ctrl_pkg.sv
rtl/irq_sample_stage.sv
rtl/irq_priority_stage.sv
rtl/irq_take_stage.sv
rtl/wfi_sleep_ctrl.sv
rtl/irq_ctrl_top.sv
tb/tb_irq_ctrl.sv

//--- rtl/core_ctrl_pkg.sv
/*
 * Core control constants for the WFI sleep path
 * Sleep entry delay and width of its down-counter
 */

package core_ctrl_pkg;

  // -------------------------------------------------------------------
  // WFI sleep entry
  // -------------------------------------------------------------------

  // Clock edges from a WFI strobe to core sleep rising
  // Only holds while no wake level and no debug request appear
  localparam int unsigned SLEEP_DELAY = 6;

  // Down-counter width, must hold SLEEP_DELAY itself
  localparam int unsigned SLEEP_CNT_W = 3;

  // Wake is level based and ignores the global interrupt enable
  // Any pending enabled line or a debug request ends WFI

endpackage : core_ctrl_pkg

//--- rtl/irq_ctrl_top.sv
/*
 * Machine-mode interrupt path top level
 * Sample, priority and take stages plus the WFI sleep controller
 */

`timescale 1ns/10ps

module irq_ctrl_top
  import irq_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic [NUM_IRQ-1:0] irq_i,
  input  logic               mie_we_i,
  input  logic [NUM_IRQ-1:0] mie_wdata_i,
  input  logic               mstatus_mie_we_i,
  input  logic               mstatus_mie_wdata_i,
  input  logic               mret_i,
  input  logic               wfi_i,
  input  logic               debug_req_i,
  output logic [NUM_IRQ-1:0] mip_o,
  output logic [NUM_IRQ-1:0] mie_o,
  output logic               mstatus_mie_o,
  output logic               irq_ack_o,
  output irq_id_t            irq_id_o,
  output logic               core_sleep_o
);

  logic [NUM_IRQ-1:0] mip;
  logic               wake;
  logic               win_valid;
  irq_id_t            win_id;

  // -------------------------------------------------------------------
  // Three-stage interrupt pipeline, irq_i to ack in 3 edges
  // -------------------------------------------------------------------
  irq_sample_stage u_sample (
    .clk_i, .rst_ni, .irq_i, .mip_o(mip)
  );

  irq_priority_stage u_priority (
    .clk_i, .rst_ni, .mip_i(mip), .mie_we_i, .mie_wdata_i, .mie_o,
    .wake_o(wake), .win_valid_o(win_valid), .win_id_o(win_id)
  );

  irq_take_stage u_take (
    .clk_i, .rst_ni, .win_valid_i(win_valid), .win_id_i(win_id),
    .mstatus_mie_we_i, .mstatus_mie_wdata_i, .mret_i,
    .mstatus_mie_o, .irq_ack_o, .irq_id_o
  );

  // Sleep sits beside the priority stage and uses its wake level
  wfi_sleep_ctrl u_sleep (
    .clk_i, .rst_ni, .wfi_i, .wake_i(wake), .debug_req_i, .core_sleep_o
  );

  assign mip_o = mip;

endmodule : irq_ctrl_top

//--- rtl/irq_pkg.sv
/*
 * Interrupt numbering shared by the interrupt path and its testbench
 * Line count, id width, implemented-line mask and id type
 */

package irq_pkg;

  // -------------------------------------------------------------------
  // Line numbering
  // -------------------------------------------------------------------

  // Total external interrupt lines seen by the core
  localparam int unsigned NUM_IRQ = 32;

  // Width of an encoded interrupt id, enough for lines 0..31
  localparam int unsigned IRQ_ID_W = 5;

  // Implemented lines
  // Platform lines 31..16, machine external 11, timer 7, software 3
  // Every other position is reserved and always reads zero in mip
  localparam logic [NUM_IRQ-1:0] VALID_IRQ_MASK = 32'hffff_0888;

  // Encoded interrupt id as carried on the ack side
  typedef logic [IRQ_ID_W-1:0] irq_id_t;

  // -------------------------------------------------------------------
  // Fixed priority order
  // -------------------------------------------------------------------
  // Highest numbered pending enabled line among 31..16 wins
  // With none of those present the order is 11, then 3, then 7
  // So software beats timer, unlike the raw line numbers suggest
  // Priority is fixed, there is no programmable level or threshold

endpackage : irq_pkg

//--- rtl/irq_priority_stage.sv
/*
 * Interrupt priority stage
 * Holds mie, masks mip with it, registers the fixed-priority winner
 * Also gives the unregistered wake level for the sleep controller
 */

`timescale 1ns/10ps

module irq_priority_stage
  import irq_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,
  // Pending lines from the sample stage
  input  logic [NUM_IRQ-1:0] mip_i,
  // Software write port for mie
  input  logic               mie_we_i,
  input  logic [NUM_IRQ-1:0] mie_wdata_i,
  output logic [NUM_IRQ-1:0] mie_o,
  // Any pending enabled line, combinational
  output logic               wake_o,
  // Registered winner towards the take stage
  output logic               win_valid_o,
  output irq_id_t            win_id_o
);

  logic [NUM_IRQ-1:0] mie_q;
  logic [NUM_IRQ-1:0] pend_en;
  logic               win_valid_d;
  logic               win_valid_q;
  irq_id_t            win_id_d;
  irq_id_t            win_id_q;

  // -------------------------------------------------------------------
  // Enable register
  // -------------------------------------------------------------------
  // Writes to reserved positions are dropped
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mie_q <= '0;
    end else if (mie_we_i) begin
      mie_q <= mie_wdata_i & VALID_IRQ_MASK;
    end
  end

  assign pend_en = mip_i & mie_q;

  // Wake does not look at the global enable
  assign wake_o = |pend_en;

  // -------------------------------------------------------------------
  // Fixed priority pick
  // -------------------------------------------------------------------
  // Later assignments override earlier ones, so the lowest priority
  // line 7 is tested first, then 3, then 11, then 16 up to 31
  always_comb begin
    win_valid_d = |pend_en;
    win_id_d    = '0;
    if (pend_en[7])  win_id_d = irq_id_t'(7);
    if (pend_en[3])  win_id_d = irq_id_t'(3);
    if (pend_en[11]) win_id_d = irq_id_t'(11);
    for (int i = 16; i < NUM_IRQ; i++) begin
      if (pend_en[i]) win_id_d = irq_id_t'(i);
    end
  end

  // Winner register towards the take stage
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      win_valid_q <= 1'b0;
      win_id_q    <= '0;
    end else begin
      win_valid_q <= win_valid_d;
      win_id_q    <= win_id_d;
    end
  end

  assign mie_o       = mie_q;
  assign win_valid_o = win_valid_q;
  assign win_id_o    = win_id_q;

endmodule : irq_priority_stage

//--- rtl/irq_sample_stage.sv
/*
 * Interrupt sample stage
 * Flops the raw lines into mip, reserved positions forced to zero
 */

`timescale 1ns/10ps

module irq_sample_stage
  import irq_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,
  // Raw external interrupt lines, level sensitive
  input  logic [NUM_IRQ-1:0] irq_i,
  // Pending register as software would read it
  output logic [NUM_IRQ-1:0] mip_o
);

  logic [NUM_IRQ-1:0] mip_q;
  logic [NUM_IRQ-1:0] mip_d;

  // Drop reserved lines before the flop
  // so they can never reach the priority logic
  assign mip_d = irq_i & VALID_IRQ_MASK;

  // Sampled every cycle, no hold or clear from software
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mip_q <= '0;
    end else begin
      mip_q <= mip_d;
    end
  end

  // One cycle after irq_i
  assign mip_o = mip_q;

endmodule : irq_sample_stage

//--- rtl/irq_take_stage.sv
/*
 * Interrupt take stage
 * Global enable bit, single-cycle ack pulse and latched id
 */

`timescale 1ns/10ps

module irq_take_stage
  import irq_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  // Winner from the priority stage
  input  logic    win_valid_i,
  input  irq_id_t win_id_i,
  // Software write of mstatus.MIE
  input  logic    mstatus_mie_we_i,
  input  logic    mstatus_mie_wdata_i,
  // Return from trap, restores the global enable
  input  logic    mret_i,
  output logic    mstatus_mie_o,
  output logic    irq_ack_o,
  output irq_id_t irq_id_o
);

  logic    mstatus_mie_q;
  logic    ack_q;
  irq_id_t id_q;
  logic    take;

  // Interrupt is taken only with the global enable set
  assign take = win_valid_i & mstatus_mie_q;

  // Global enable
  // Trap entry clears it and beats both write and mret
  // A software write beats mret in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mstatus_mie_q <= 1'b0;
    end else if (take) begin
      mstatus_mie_q <= 1'b0;
    end else if (mstatus_mie_we_i) begin
      mstatus_mie_q <= mstatus_mie_wdata_i;
    end else if (mret_i) begin
      mstatus_mie_q <= 1'b1;
    end
  end

  // Ack is a pulse by construction, the take itself clears the enable
  // Id holds its value until the next ack
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
      id_q  <= '0;
    end else begin
      ack_q <= take;
      if (take) id_q <= win_id_i;
    end
  end

  assign mstatus_mie_o = mstatus_mie_q;
  assign irq_ack_o     = ack_q;
  assign irq_id_o      = id_q;

endmodule : irq_take_stage

//--- rtl/wfi_sleep_ctrl.sv
/*
 * WFI sleep controller
 * WFI state, entry delay down-counter and core sleep flag
 */

`timescale 1ns/10ps

module wfi_sleep_ctrl
  import core_ctrl_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,
  // Strobe from a retired WFI instruction
  input  logic wfi_i,
  // Pending enabled interrupt level
  input  logic wake_i,
  // External debug request, level
  input  logic debug_req_i,
  output logic core_sleep_o
);

  logic                   in_wfi_q;
  logic                   sleep_q;
  logic [SLEEP_CNT_W-1:0] cnt_q;
  logic                   wake_any;

  assign wake_any = wake_i | debug_req_i;

  // Wake wins over a WFI strobe in the same cycle
  // A repeated strobe while already in WFI is ignored
  // Counter runs SLEEP_DELAY..1, sleep rises on the step from 1 to 0
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      in_wfi_q <= 1'b0;
      sleep_q  <= 1'b0;
      cnt_q    <= '0;
    end else if (wake_any) begin
      in_wfi_q <= 1'b0;
      sleep_q  <= 1'b0;
      cnt_q    <= '0;
    end else if (wfi_i && !in_wfi_q) begin
      in_wfi_q <= 1'b1;
      cnt_q    <= SLEEP_CNT_W'(SLEEP_DELAY);
    end else if (in_wfi_q && (cnt_q != '0)) begin
      cnt_q <= cnt_q - 1'b1;
      if (cnt_q == SLEEP_CNT_W'(1)) sleep_q <= 1'b1;
    end
  end

  assign core_sleep_o = sleep_q;

endmodule : wfi_sleep_ctrl

//--- run_sim.sh
#!/bin/sh
# Build and run the interrupt path testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_irq_ctrl -f list.f -o sim_irq_ctrl

out=$(./obj_dir/sim_irq_ctrl)
echo "$out"

if echo "$out" | grep -qx "Test OK"; then
  exit 0
fi
exit 1

//--- tb/tb_irq_ctrl.sv
/*
 * Testbench for the machine-mode interrupt path
 * Clock, reset, xorshift stimulus, cycle model, checks and timeout
 */

`timescale 1ns/10ps

module tb_irq_ctrl
  import irq_pkg::*;
  import core_ctrl_pkg::*;
();

  // Test lengths in cycles, used for the timeout limit
  localparam int unsigned T_MIP   = 200;
  localparam int unsigned T_PRIO  = 400;
  localparam int unsigned T_GEN   = 400;
  localparam int unsigned T_SLEEP = SLEEP_DELAY + 5;
  localparam int unsigned T_WAKE  = 8 * (SLEEP_DELAY + 6);
  localparam int unsigned LIMIT   = 16 + T_MIP + T_PRIO + T_GEN + T_SLEEP + T_WAKE + 100;

  logic clk_i, rst_ni, mie_we, mst_we, mst_wdata, mret, wfi, dbg;
  logic [31:0] irq, mie_wdata, rng;
  logic [31:0] mip_o, mie_o;
  logic mstatus_mie_o, irq_ack_o, core_sleep_o, prev_ack;
  irq_id_t irq_id_o;
  int unsigned cycle_cnt, errors, checks;

  // Model state, shadows of the DUT registers
  logic [31:0] m_mip, m_mie;
  logic m_win_valid, m_mst, m_ack, m_wfi, m_sleep;
  irq_id_t m_win_id, m_id;
  int unsigned m_cnt;

  irq_ctrl_top dut (
    .clk_i, .rst_ni, .irq_i(irq), .mie_we_i(mie_we), .mie_wdata_i(mie_wdata),
    .mstatus_mie_we_i(mst_we), .mstatus_mie_wdata_i(mst_wdata), .mret_i(mret),
    .wfi_i(wfi), .debug_req_i(dbg), .mip_o, .mie_o, .mstatus_mie_o, .irq_ack_o,
    .irq_id_o, .core_sleep_o
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    return s ^ (s << 5);
  endfunction

  // Winner by the fixed order
  // Highest of 31..16 first, then 11, 3 and 7
  function automatic irq_id_t pick_winner(input logic [31:0] pe);
    int i;
    for (i = 31; i >= 16; i--) begin
      if (pe[i]) return irq_id_t'(i);
    end
    if (pe[11]) return irq_id_t'(11);
    if (pe[3]) return irq_id_t'(3);
    if (pe[7]) return irq_id_t'(7);
    return '0;
  endfunction

  // -------------------------------------------------------------------
  // Reference model, one update per rising edge
  // -------------------------------------------------------------------
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      m_mip       <= '0;
      m_mie       <= '0;
      m_win_valid <= 1'b0;
      m_win_id    <= '0;
      m_mst       <= 1'b0;
      m_ack       <= 1'b0;
      m_id        <= '0;
      m_wfi       <= 1'b0;
      m_sleep     <= 1'b0;
      m_cnt       <= 0;
    end else begin
      m_mip <= irq & VALID_IRQ_MASK;
      if (mie_we) m_mie <= mie_wdata & VALID_IRQ_MASK;
      m_win_valid <= |(m_mip & m_mie);
      m_win_id <= pick_winner(m_mip & m_mie);
      // Taking clears the enable, then a write, then mret
      m_ack <= m_win_valid && m_mst;
      if (m_win_valid && m_mst) begin
        m_mst <= 1'b0;
        m_id <= m_win_id;
      end else if (mst_we) m_mst <= mst_wdata;
      else if (mret) m_mst <= 1'b1;
      // Sleep counts edges since the strobe and wake clears everything
      if ((|(m_mip & m_mie)) || dbg) begin
        m_wfi   <= 1'b0;
        m_sleep <= 1'b0;
        m_cnt   <= 0;
      end else if (wfi && !m_wfi) begin
        m_wfi <= 1'b1;
        m_cnt <= 0;
      end else if (m_wfi && !m_sleep) begin
        m_cnt <= m_cnt + 1;
        if (m_cnt + 1 == SLEEP_DELAY) m_sleep <= 1'b1;
      end
    end
  end

  // Run limit
  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= LIMIT) begin
      $display("Run timed out after %0d cycles without finishing the tests", cycle_cnt);
      $display("Test FAILED");
      $finish;
    end
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got %h expected %h", name, got, exp);
    end
  endtask

  // Compare at the falling edge where outputs have settled
  // The caller drives the next inputs right after it returns
  task automatic tick();
    @(negedge clk_i);
    check("mip_o", mip_o, m_mip);
    check("mie_o", mie_o, m_mie);
    check("mstatus_mie_o", 32'(mstatus_mie_o), 32'(m_mst));
    check("irq_ack_o", 32'(irq_ack_o), 32'(m_ack));
    check("irq_id_o", 32'(irq_id_o), 32'(m_id));
    check("core_sleep_o", 32'(core_sleep_o), 32'(m_sleep));
    if (prev_ack && irq_ack_o) begin
      errors++;
      $display("Acknowledge stayed high for two cycles in a row");
    end
    prev_ack = irq_ack_o;
  endtask

  task automatic drive_idle();
    mie_we = 1'b0;
    mst_we = 1'b0;
    mret   = 1'b0;
    wfi    = 1'b0;
    dbg    = 1'b0;
  endtask

  task automatic print_result(input string name, input int unsigned err0);
    $display("%s: done, %0d errors", name, errors - err0);
  endtask

  // Random traffic in three modes
  // Mode 0 tracks mip only, 1 adds mret every cycle, 2 random writes and mret
  task automatic random_traffic(input string name, input int unsigned len, input int mode);
    int unsigned err0, n;
    logic [31:0] a, b;
    err0 = errors;
    for (n = 0; n < len; n++) begin
      tick();
      drive_idle();
      rng = xorshift32(rng);
      a = rng;
      rng = xorshift32(rng);
      b = rng;
      irq = (mode == 0) ? a : ((a & b & {b[15:0], a[31:16]}) | (b & 32'h0000_0888));
      mie_we = (rng[26:24] == 3'd0);
      mie_wdata = a ^ {b[7:0], b[31:8]};
      mret = (mode == 1) || (mode == 2 && rng[29:27] == 3'd0);
      mst_we = (mode == 2) && (rng[31:30] == 2'd0);
      mst_wdata = rng[23];
    end
    print_result(name, err0);
  endtask

  task automatic sleep_entry();
    int unsigned err0;
    err0 = errors;
    mie_we = 1'b1;
    mie_wdata = '0;
    tick();
    drive_idle();
    tick();
    wfi = 1'b1;
    tick();
    wfi = 1'b0;
    repeat (SLEEP_DELAY - 1) tick();
    check("core_sleep_o", 32'(core_sleep_o), 32'd0);
    tick();
    check("core_sleep_o", 32'(core_sleep_o), 32'd1);
    repeat (2) tick();
    print_result("sleep_entry", err0);
  endtask

  // Each round disables all lines, sleeps, then wakes the core
  // Even rounds wake by debug, odd rounds by enabling a pending line
  task automatic wake_from_sleep();
    int unsigned err0, r;
    err0 = errors;
    for (r = 0; r < 8; r++) begin
      rng = xorshift32(rng);
      drive_idle();
      irq = rng | 32'h0000_0800;
      mie_we = 1'b1;
      mie_wdata = '0;
      mst_we = 1'b1;
      mst_wdata = 1'b0;
      tick();
      drive_idle();
      wfi = 1'b1;
      tick();
      wfi = 1'b0;
      repeat (SLEEP_DELAY) tick();
      check("core_sleep_o", 32'(core_sleep_o), 32'd1);
      if (!r[0]) dbg = 1'b1;
      else begin
        mie_we = 1'b1;
        mie_wdata = (rng & VALID_IRQ_MASK) | 32'h0000_0800;
      end
      tick();
      drive_idle();
      repeat (3) tick();
      check("core_sleep_o", 32'(core_sleep_o), 32'd0);
    end
    print_result("wake", err0);
  endtask

  initial begin
    rng       = 32'h51cc_e6f4;
    cycle_cnt = 0;
    errors    = 0;
    checks    = 0;
    prev_ack  = 1'b0;
    irq       = '0;
    mie_wdata = '0;
    mst_wdata = 1'b0;
    rst_ni    = 1'b0;
    drive_idle();
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    random_traffic("mip_track", T_MIP, 0);
    random_traffic("priority", T_PRIO, 1);
    random_traffic("global_enable", T_GEN, 2);
    sleep_entry();
    wake_from_sleep();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) $display("Test OK");
    else $display("Test FAILED");
    $finish;
  end

endmodule : tb_irq_ctrl
